// ==== hw/synctimer_fmt_pkg.sv ====
// timer numeric formats
package synctimer_fmt_pkg;

    // --------------------------------------
    // widths
    // --------------------------------------
    localparam int TIMER_WIDTH = 32;
    localparam int CYCLE_WIDTH = 24;    // raw cycle count
    localparam int ERROR_WIDTH = 24;    // integer part of the error
    localparam int ERROR_Q     = 8;     // fraction bits, error and period
    localparam int CYCLE_Q     = 2;     // fraction bits, cycle estimate

    localparam int CYCLE_BITS  = CYCLE_WIDTH + CYCLE_Q;
    localparam int ERROR_BITS  = ERROR_WIDTH + ERROR_Q;
    localparam int ADJUST_BITS = CYCLE_WIDTH + ERROR_Q;

    // --------------------------------------
    // numeric types
    // --------------------------------------
    typedef logic [TIMER_WIDTH-1:0]       t_time;
    typedef logic [CYCLE_BITS-1:0]        t_cycle;   // unsigned
    typedef logic signed [ERROR_BITS-1:0] t_error;
    typedef logic [ADJUST_BITS-1:0]       t_adjust;  // period between pulses

    // one local clock in period units
    localparam t_adjust ADJUST_STEP = t_adjust'(1) << ERROR_Q;

endpackage

// ==== hw/synctimer_msg_pkg.sv ====
// timer message structs
package synctimer_msg_pkg;

    import synctimer_fmt_pkg::*;

    // correction event from the reference side
    typedef struct packed {
        logic  valid;
        logic  override;    // hard load of the timer
        t_time ref_time;
    } correct_t;

    // adjust limits, error format
    typedef struct packed {
        t_error adjust_min;
        t_error adjust_max;
    } limit_t;

    // pacing command
    typedef struct packed {
        logic    zero;      // nothing to emit
        logic    sign;      // negative adjust
        t_adjust period;
    } adjust_cmd_t;

endpackage

// ==== hw/lpf_estimator.sv ====
// first-order low-pass estimator
`timescale 1ns/10ps

module lpf_estimator #(
    parameter type         t_value     = logic [31:0],
    parameter int unsigned GAIN        = 2,
    parameter bit          SIGNED_MATH = 1'b0
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   clear,           // drop the history
    input  t_value bias,            // taken off the held value for the prediction
    input  logic   obs_valid,
    input  t_value obs,
    output t_value estimate,
    output logic   estimate_valid
);

    t_value predict;
    t_value blend;

    function automatic t_value scale(input t_value v);
        if (SIGNED_MATH) begin
            return t_value'($signed(v) >>> GAIN);
        end else begin
            return t_value'($unsigned(v) >> GAIN);
        end
    endfunction

    assign predict = estimate - bias;
    assign blend   = predict - scale(predict) + scale(obs);

    always_ff @(posedge clk) begin
        if (reset) begin
            estimate_valid <= 1'b0;
        end else if (obs_valid) begin
            estimate_valid <= 1'b1;
        end else if (clear) begin
            estimate_valid <= 1'b0;
        end
    end

    // first sample after reset or clear passes straight through
    always_ff @(posedge clk) begin
        if (obs_valid) begin
            estimate <= (estimate_valid && !clear) ? blend : obs;
        end
    end

endmodule

// ==== hw/adjust_limit_regs.sv ====
// adjust limit registers
`timescale 1ns/10ps

module adjust_limit_regs (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      limit_write,
    input  synctimer_msg_pkg::limit_t limit_wdata,    // whole timer units
    output synctimer_msg_pkg::limit_t limits          // error Q format
);

    import synctimer_fmt_pkg::*;

    // zero limits keep the adjust output quiet
    always_ff @(posedge clk) begin
        if (reset) begin
            limits <= '0;
        end else if (limit_write) begin
            limits.adjust_min <= limit_wdata.adjust_min <<< ERROR_Q;
            limits.adjust_max <= limit_wdata.adjust_max <<< ERROR_Q;
        end
    end

endmodule

// ==== hw/cycle_estimator.sv ====
// local cycle count estimator
`timescale 1ns/10ps

module cycle_estimator #(
    parameter int unsigned LPF_GAIN_CYCLE = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  synctimer_msg_pkg::correct_t correct,
    output synctimer_fmt_pkg::t_cycle   cycle,
    output logic                        cycle_valid
);

    import synctimer_fmt_pkg::*;

    typedef logic [CYCLE_WIDTH-1:0] t_count;

    t_count count;
    logic   count_run;      // set by the first correction
    t_cycle obs;
    logic   obs_valid;

    // --------------------------------------
    // clocks between corrections
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            count     <= '0;
            count_run <= 1'b0;
            obs_valid <= 1'b0;
        end else begin
            count     <= count + t_count'(1);
            obs_valid <= correct.valid & count_run;
            if (correct.valid) begin
                count     <= t_count'(1);
                count_run <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (correct.valid) begin
            obs <= t_cycle'(count) << CYCLE_Q;  // to Q format
        end
    end

    // --------------------------------------
    // filter
    // --------------------------------------
    lpf_estimator #(
        .t_value     (t_cycle),
        .GAIN        (LPF_GAIN_CYCLE),
        .SIGNED_MATH (1'b0)
    ) i_lpf (
        .clk            (clk),
        .reset          (reset),
        .clear          (1'b0),
        .bias           (t_cycle'(0)),
        .obs_valid      (obs_valid),
        .obs            (obs),
        .estimate       (cycle),
        .estimate_valid (cycle_valid)
    );

endmodule

// ==== hw/phase_error_estimator.sv ====
// phase error estimator
`timescale 1ns/10ps

module phase_error_estimator #(
    parameter int unsigned LPF_GAIN_PHASE = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  synctimer_msg_pkg::correct_t correct,
    input  synctimer_fmt_pkg::t_time    current_time,
    input  synctimer_msg_pkg::limit_t   limits,
    output synctimer_fmt_pkg::t_error   adjust,
    output logic                        error_valid
);

    import synctimer_fmt_pkg::*;

    t_error     obs;
    logic       obs_valid;
    logic       clear;
    t_error     estimate;
    logic       estimate_valid;
    t_error     lim_min;
    t_error     lim_max;
    logic [2:0] delay;

    assign lim_min     = limits.adjust_min;
    assign lim_max     = limits.adjust_max;
    assign error_valid = delay[2];

    // --------------------------------------
    // observation
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            obs_valid <= 1'b0;
            clear     <= 1'b0;
        end else begin
            obs_valid <= correct.valid;
            clear     <= correct.valid & correct.override;
        end
    end

    always_ff @(posedge clk) begin
        if (correct.valid) begin
            if (correct.override) begin
                obs <= '0;  // timer is loaded, nothing left to correct
            end else begin
                obs <= t_error'(correct.ref_time - current_time) <<< ERROR_Q;
            end
        end
    end

    // prediction is the held estimate less the adjust already applied
    lpf_estimator #(
        .t_value     (t_error),
        .GAIN        (LPF_GAIN_PHASE),
        .SIGNED_MATH (1'b1)
    ) i_lpf (
        .clk            (clk),
        .reset          (reset),
        .clear          (clear),
        .bias           (adjust),
        .obs_valid      (obs_valid),
        .obs            (obs),
        .estimate       (estimate),
        .estimate_valid (estimate_valid)
    );

    // --------------------------------------
    // limiter
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            delay  <= '0;
            adjust <= '0;
        end else begin
            delay <= {delay[1] & estimate_valid, delay[0], correct.valid};
            if (delay[1]) begin
                if (estimate < lim_min) begin
                    adjust <= lim_min;
                end else if (estimate > lim_max) begin
                    adjust <= lim_max;
                end else begin
                    adjust <= estimate;
                end
            end
        end
    end

endmodule

// ==== hw/period_divider.sv ====
// adjust period divider
`timescale 1ns/10ps

module period_divider (
    input  logic                           clk,
    input  logic                           reset,
    input  synctimer_fmt_pkg::t_error      adjust,
    input  logic                           error_valid,
    input  synctimer_fmt_pkg::t_cycle      cycle,
    input  logic                           cycle_valid,
    output synctimer_msg_pkg::adjust_cmd_t cmd,
    output logic                           cmd_valid
);

    import synctimer_fmt_pkg::*;

    localparam int SHIFT  = 2 * ERROR_Q - CYCLE_Q;   // cycle to 2*ERROR_Q fraction bits
    localparam int DVD_W  = $bits(t_cycle) + SHIFT;
    localparam int DIV_W  = $bits(t_error);
    localparam int QUO_W  = $bits(t_adjust);
    localparam int STEP_W = $clog2(QUO_W + 1);

    logic [DVD_W-1:0]  dividend;
    logic [DIV_W-1:0]  magnitude;
    logic              start;
    logic              busy;
    logic [STEP_W-1:0] step;
    logic [DIV_W-1:0]  divisor;
    logic [DIV_W-1:0]  rem;
    logic [DIV_W:0]    rem_shift;
    logic              rem_fit;
    t_adjust           quo;         // dividend bits out, quotient bits in
    logic              overflow;
    logic              sign;
    t_adjust           period;

    assign dividend  = DVD_W'(cycle) << SHIFT;
    assign magnitude = adjust[DIV_W-1] ? DIV_W'(-adjust) : DIV_W'(adjust);
    assign start     = error_valid & cycle_valid & ~busy;  // dropped while busy
    assign rem_shift = {rem, quo[QUO_W-1]};
    assign rem_fit   = rem_shift >= {1'b0, divisor};
    assign period    = overflow ? '1 : (quo < ADJUST_STEP) ? '0 : quo - ADJUST_STEP;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy      <= 1'b0;
            step      <= '0;
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= 1'b0;
            if (start) begin
                if (adjust == '0) begin
                    cmd_valid <= 1'b1;  // no division needed
                end else begin
                    busy <= 1'b1;
                    step <= '0;
                end
            end else if (busy) begin
                if (step == STEP_W'(QUO_W)) begin
                    busy      <= 1'b0;
                    cmd_valid <= 1'b1;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // restoring division, one quotient bit per clock
    always_ff @(posedge clk) begin
        if (start) begin
            divisor  <= magnitude;
            sign     <= adjust[DIV_W-1];
            rem      <= DIV_W'(dividend[DVD_W-1:QUO_W]);
            quo      <= dividend[QUO_W-1:0];
            overflow <= DIV_W'(dividend[DVD_W-1:QUO_W]) >= magnitude;
            if (adjust == '0) begin
                cmd <= '{zero: 1'b1, sign: 1'b0, period: '0};
            end
        end else if (busy) begin
            if (step != STEP_W'(QUO_W)) begin
                rem <= rem_fit ? DIV_W'(rem_shift - {1'b0, divisor}) : rem_shift[DIV_W-1:0];
                quo <= {quo[QUO_W-2:0], rem_fit};
            end else begin
                cmd <= '{zero: 1'b0, sign: sign, period: period};
            end
        end
    end

endmodule

// ==== hw/adjust_pacer.sv ====
// adjust pulse pacer
`timescale 1ns/10ps

module adjust_pacer (
    input  logic                           clk,
    input  logic                           reset,
    input  synctimer_msg_pkg::adjust_cmd_t cmd,
    input  logic                           cmd_valid,
    output logic                           adjust_sign,
    output logic                           adjust_valid,
    input  logic                           adjust_ready
);

    import synctimer_fmt_pkg::*;
    import synctimer_msg_pkg::*;

    adjust_cmd_t cur;           // command in use
    adjust_cmd_t nxt;           // waits for a pulse boundary
    logic        nxt_valid;
    adjust_cmd_t pend;
    logic        pend_valid;
    t_adjust     count;         // one unit per clock
    logic        hit;
    logic        boundary;

    assign hit        = !cur.zero && (count >= cur.period);
    assign boundary   = cur.zero || hit;
    assign pend       = cmd_valid ? cmd : nxt;    // newest command wins
    assign pend_valid = cmd_valid | nxt_valid;

    // --------------------------------------
    // fractional counter
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            cur.zero  <= 1'b1;
            nxt_valid <= 1'b0;
            count     <= '0;
        end else if (boundary && pend_valid) begin
            cur       <= pend;
            nxt_valid <= 1'b0;
            count     <= '0;
        end else begin
            if (cmd_valid) begin
                nxt       <= cmd;
                nxt_valid <= 1'b1;
            end
            if (hit) begin
                count <= count - cur.period;    // carry the remainder
            end else if (!cur.zero) begin
                count <= count + ADJUST_STEP;
            end
        end
    end

    // --------------------------------------
    // output register
    // --------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            adjust_valid <= 1'b0;
        end else begin
            if (adjust_ready) begin
                adjust_valid <= 1'b0;
            end
            if (hit) begin
                adjust_valid <= 1'b1;   // merges into a pending pulse
            end
        end
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            adjust_sign <= cur.sign;
        end
    end

endmodule

// ==== hw/synctimer_adjust.sv ====
// timer discipline adjuster
`timescale 1ns/10ps

module synctimer_adjust #(
    parameter int unsigned LPF_GAIN_CYCLE = 2,
    parameter int unsigned LPF_GAIN_PHASE = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  synctimer_msg_pkg::correct_t correct,
    input  synctimer_fmt_pkg::t_time    current_time,
    input  logic                        limit_write,
    input  synctimer_msg_pkg::limit_t   limit_wdata,
    output logic                        adjust_sign,
    output logic                        adjust_valid,
    input  logic                        adjust_ready
);

    import synctimer_fmt_pkg::*;
    import synctimer_msg_pkg::*;

    limit_t      limits;
    t_cycle      cycle;
    logic        cycle_valid;
    t_error      adjust;
    logic        error_valid;
    adjust_cmd_t cmd;
    logic        cmd_valid;

    cycle_estimator #(
        .LPF_GAIN_CYCLE (LPF_GAIN_CYCLE)
    ) i_cycle_estimator (
        .clk         (clk),
        .reset       (reset),
        .correct     (correct),
        .cycle       (cycle),
        .cycle_valid (cycle_valid)
    );

    adjust_limit_regs i_adjust_limit_regs (
        .clk         (clk),
        .reset       (reset),
        .limit_write (limit_write),
        .limit_wdata (limit_wdata),
        .limits      (limits)
    );

    phase_error_estimator #(
        .LPF_GAIN_PHASE (LPF_GAIN_PHASE)
    ) i_phase_error_estimator (
        .clk          (clk),
        .reset        (reset),
        .correct      (correct),
        .current_time (current_time),
        .limits       (limits),
        .adjust       (adjust),
        .error_valid  (error_valid)
    );

    period_divider i_period_divider (
        .clk         (clk),
        .reset       (reset),
        .adjust      (adjust),
        .error_valid (error_valid),
        .cycle       (cycle),
        .cycle_valid (cycle_valid),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid)
    );

    adjust_pacer i_adjust_pacer (
        .clk          (clk),
        .reset        (reset),
        .cmd          (cmd),
        .cmd_valid    (cmd_valid),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready)
    );

endmodule

// ==== verif/synctimer_adjust_asserts.sv ====
// adjuster interface assertions
`timescale 1ns/10ps

module synctimer_adjust_asserts (
    input logic clk,
    input logic reset,
    input logic adjust_valid,
    input logic adjust_ready,
    input logic error_valid,
    input logic cmd_valid
);

    localparam int DIV_LATENCY = 34;    // error_valid to cmd_valid through the divider

    a_valid_reset: assert property (@(posedge clk) reset |=> !adjust_valid)
        else $error("adjust_valid high after a reset cycle");

    a_valid_hold: assert property (@(posedge clk) disable iff (reset)
        adjust_valid && !adjust_ready |=> adjust_valid)
        else $error("adjust_valid dropped before adjust_ready");

    // zero adjust skips the division
    a_cmd_cause: assert property (@(posedge clk) disable iff (reset)
        cmd_valid |-> $past(error_valid) || $past(error_valid, DIV_LATENCY))
        else $error("cmd_valid without an earlier error_valid");

endmodule

bind synctimer_adjust synctimer_adjust_asserts i_asserts (.*);

// ==== verif/synctimer_adjust_tb.sv ====
// adjuster testbench
`timescale 1ns/10ps

module synctimer_adjust_tb;

    import synctimer_fmt_pkg::*;
    import synctimer_msg_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int GAIN       = 2;
    localparam int INTERVAL   = 400;
    localparam int JITTER_MAX = 15;
    localparam int N_CORRECT  = 10;
    localparam int RUN_CYCLES = 208 + N_CORRECT * (INTERVAL + JITTER_MAX) + 2500;

    logic     clk;
    logic     reset;
    correct_t correct;
    t_time    current_time;
    logic     limit_write;
    limit_t   limit_wdata;
    logic     adjust_ready;
    logic     adjust_sign;
    logic     adjust_valid;

    int          seed = 32'h6a50_c9b2;
    int          errors;
    int          checks;
    int          tests;
    int          cyc;
    int          last_cyc;
    int          handshakes;
    logic        last_sign;
    adjust_cmd_t exp_q[$];

    // reference model state
    t_cycle      m_cycle;
    logic        m_cycle_valid;
    logic        m_count_run;
    t_error      m_est;
    logic        m_est_valid;
    t_error      m_adj;
    t_error      m_min;
    t_error      m_max;
    adjust_cmd_t m_cmd;

    synctimer_adjust #(
        .LPF_GAIN_CYCLE (GAIN),
        .LPF_GAIN_PHASE (GAIN)
    ) i_dut (
        .clk          (clk),
        .reset        (reset),
        .correct      (correct),
        .current_time (current_time),
        .limit_write  (limit_write),
        .limit_wdata  (limit_wdata),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not finish", RUN_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    always @(posedge clk) begin
        current_time <= current_time + 1;   // free-running local timer
        cyc          <= cyc + 1;
    end

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic compare_cmd(input adjust_cmd_t act, input adjust_cmd_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: cmd expected zero=%b sign=%b period=%h got %b %b %h",
                $time, exp.zero, exp.sign, exp.period, act.zero, act.sign, act.period);
        end
    endtask

    task automatic compare_sign(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Fail at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input longint act, input longint exp,
                                 input int tol);
        checks++;
        if (act < exp - tol || act > exp + tol) begin
            errors++;
            $display("Fail at %0t: %s expected %0d (+-%0d) got %0d", $time, name, exp, tol, act);
        end
    endtask

    // divider output checked in issue order
    always @(posedge clk) begin
        if (!reset && i_dut.cmd_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("divider produced a command that no correction asked for");
            end else begin
                compare_cmd(i_dut.cmd, exp_q.pop_front());
            end
        end
        if (adjust_valid && adjust_ready) begin
            handshakes <= handshakes + 1;
            last_sign  <= adjust_sign;
        end
    end

    // ----------------------------------------
    // reference model
    // ----------------------------------------
    function automatic t_error clamp_adjust(input t_error e, input t_error lo, input t_error hi);
        if (e < lo) begin
            return lo;
        end
        if (e > hi) begin
            return hi;
        end
        return e;
    endfunction

    function automatic adjust_cmd_t model_cmd(input t_cycle c, input t_error a);
        adjust_cmd_t r;
        logic [63:0] dvd;
        logic [63:0] mag;
        logic [63:0] q;
        r = '0;
        if (a == 0) begin
            r.zero = 1'b1;
            return r;
        end
        mag    = (a < 0) ? 64'(-a) : 64'(a);
        dvd    = 64'(c) << (2 * ERROR_Q - CYCLE_Q);   // rescale to 2*ERROR_Q fraction
        q      = dvd / mag;
        r.sign = (a < 0);
        if (q >= (64'd1 << $bits(t_adjust))) begin
            r.period = '1;
        end else if (q < 64'(ADJUST_STEP)) begin
            r.period = '0;
        end else begin
            r.period = t_adjust'(q - 64'(ADJUST_STEP));
        end
        return r;
    endfunction

    // ----------------------------------------
    // stimulus helpers
    // ----------------------------------------
    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic write_limits(input int lo, input int hi);
        @(posedge clk);
        limit_wdata <= '{adjust_min: t_error'(lo), adjust_max: t_error'(hi)};
        limit_write <= 1'b1;
        m_min = t_error'(lo) <<< ERROR_Q;
        m_max = t_error'(hi) <<< ERROR_Q;
        @(posedge clk);
        limit_write <= 1'b0;
    endtask

    task automatic send_correction(input logic ov, input int lead);
        t_cycle c_obs;
        t_error p_obs;
        t_error pred;
        @(posedge clk);
        correct <= '{valid: 1'b1, override: ov,
                     ref_time: t_time'(current_time + t_time'(lead) + 1)};
        if (m_count_run) begin
            c_obs = t_cycle'(cyc - last_cyc) << CYCLE_Q;
            if (m_cycle_valid) begin
                m_cycle = m_cycle - (m_cycle >> GAIN) + (c_obs >> GAIN);
            end else begin
                m_cycle = c_obs;
            end
            m_cycle_valid = 1'b1;
        end
        m_count_run = 1'b1;
        last_cyc    = cyc;
        p_obs = ov ? t_error'(0) : (t_error'(lead) <<< ERROR_Q);
        if (!m_est_valid || ov) begin
            m_est = p_obs;
        end else begin
            pred  = m_est - m_adj;
            m_est = pred - (pred >>> GAIN) + (p_obs >>> GAIN);
        end
        m_est_valid = 1'b1;
        m_adj       = clamp_adjust(m_est, m_min, m_max);
        if (m_cycle_valid) begin
            m_cmd = model_cmd(m_cycle, m_adj);
            exp_q.push_back(m_cmd);
        end
        @(posedge clk);
        correct <= '0;
    endtask

    function automatic int jitter();
        int j;
        j = $random(seed);
        return j & JITTER_MAX;
    endfunction

    task automatic wait_pulse(output int at_cyc);
        int guard;
        guard = 0;
        at_cyc = -1;
        while (at_cyc < 0 && guard < 200) begin
            @(posedge clk);
            guard++;
            if (adjust_valid) begin
                at_cyc = cyc;
            end
        end
        if (at_cyc < 0) begin
            errors++;
            $display("no adjust pulse seen within 200 cycles");
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errs_before);
        end
    endtask

    // ----------------------------------------
    // directed tests
    // ----------------------------------------
    task automatic quiet_after_reset();
        int e0;
        int high;
        e0   = errors;
        high = 0;
        repeat (200) begin
            @(posedge clk);
            if (adjust_valid) begin
                high++;
            end
        end
        compare_count("adjust_valid high cycles", high, 0, 0);
        finish_test("quiet after reset", e0);
    endtask

    task automatic constant_lead_pulses();
        int e0;
        int hs0;
        e0 = errors;
        write_limits(-50, 50);
        repeat (5) begin
            send_correction(1'b0, 10);
            idle(INTERVAL + jitter());
        end
        send_correction(1'b0, 10);
        hs0 = handshakes;
        idle(INTERVAL);
        compare_count("pulses per interval", handshakes - hs0,
            longint'(INTERVAL) * ADJUST_STEP / (longint'(m_cmd.period) + ADJUST_STEP), 1);
        compare_sign("adjust_sign", last_sign, m_adj < 0);
        finish_test("constant lead", e0);
    endtask

    task automatic override_stops_pulses();
        int e0;
        int hs0;
        e0 = errors;
        send_correction(1'b1, 0);
        idle(INTERVAL);     // old command drains
        hs0 = handshakes;
        idle(INTERVAL);
        compare_count("pulses after override", handshakes - hs0, 0, 0);
        finish_test("override", e0);
    endtask

    task automatic clamped_pulse_spacing();
        int e0;
        int t0;
        int t1;
        e0 = errors;
        write_limits(-20, 20);
        repeat (2) begin
            send_correction(1'b0, -200);
            idle(100);
            wait_pulse(t0);
            wait_pulse(t1);
            compare_count("pulse spacing", t1 - t0,
                (longint'(m_cmd.period) + ADJUST_STEP - 1) / ADJUST_STEP + 1, 1);
            compare_sign("adjust_sign", adjust_sign, m_adj < 0);
            idle(INTERVAL - 100 + jitter());
        end
        finish_test("clamped spacing", e0);
    endtask

    task automatic back_pressure_hold();
        int   e0;
        int   t0;
        logic sign0;
        e0 = errors;
        @(posedge clk);
        adjust_ready <= 1'b0;
        sign0 = (m_adj < 0);
        wait_pulse(t0);
        repeat (60) begin
            @(posedge clk);
            compare_sign("adjust_valid", adjust_valid, 1'b1);
            compare_sign("adjust_sign", adjust_sign, sign0);
        end
        send_correction(1'b1, 0);   // stop new pulses
        idle(100);
        adjust_ready <= 1'b1;
        @(posedge clk);
        compare_sign("adjust_valid", adjust_valid, 1'b1);
        @(posedge clk);
        compare_sign("adjust_valid", adjust_valid, 1'b0);
        idle(50);
        finish_test("back pressure", e0);
    endtask

    initial begin
        reset         = 1'b1;
        correct       = '0;
        current_time  = '0;
        limit_write   = 1'b0;
        limit_wdata   = '0;
        adjust_ready  = 1'b1;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        cyc           = 0;
        last_cyc      = 0;
        handshakes    = 0;
        last_sign     = 1'b0;
        m_cycle       = '0;
        m_cycle_valid = 1'b0;
        m_count_run   = 1'b0;
        m_est         = '0;
        m_est_valid   = 1'b0;
        m_adj         = '0;
        m_min         = '0;
        m_max         = '0;
        m_cmd         = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;

        quiet_after_reset();
        constant_lead_pulses();
        override_stops_pulses();
        clamped_pulse_spacing();
        back_pressure_hold();
        compare_count("commands still expected", exp_q.size(), 0, 0);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/synctimer_fmt_pkg.sv
hw/synctimer_msg_pkg.sv
hw/lpf_estimator.sv
hw/adjust_limit_regs.sv
hw/cycle_estimator.sv
hw/phase_error_estimator.sv
hw/period_divider.sv
hw/adjust_pacer.sv
hw/synctimer_adjust.sv
verif/synctimer_adjust_asserts.sv
verif/synctimer_adjust_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the adjuster testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
    --top-module synctimer_adjust_tb -Mdir obj_dir \
    && ./obj_dir/Vsynctimer_adjust_tb > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^Simulation completed successfully$" sim.log && echo "PASS" && exit 0 \
    || { echo "FAIL"; exit 1; }
